//--- sim.f
uart_pkg.sv
mmio_pkg.sv
uart_rx.sv
mmio_uart_rx.sv
uart_mmio_top.sv
tb_clkgen.sv
tb_top_sva.sv
tb_top.sv

//--- Makefile
# the simulator is rebuilt only when a source or the file list changes
SOURCES := $(wildcard *.sv) sim.f

obj_dir/Vtb_top: $(SOURCES)
	verilator --binary --assert --top-module tb_top -f sim.f

run: obj_dir/Vtb_top
	./obj_dir/Vtb_top | tee sim.log
	grep -q "^TEST PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top
    import uart_pkg::*;
    import mmio_pkg::*;
();

    localparam int ring_bytes  = ring_words * 4;
    localparam int watchdog_ns = 1100 * 10 * clks_per_bit * 10 + 200_000;   // frames, bits, period

    logic       clk;
    logic       rst_n;
    logic       uart_rx_line;
    logic       cmd_start;
    logic       cmd_write;
    mmio_word_t addr;
    mmio_word_t wdata;
    logic       cmd_ready;
    mmio_word_t rdata;
    logic       rdata_valid;

    uart_byte_t byte_log [$];                             // every byte of a good frame, in order
    string      exp_name [$];
    mmio_word_t exp_value [$];
    mmio_word_t exp_mask [$];
    bit         exp_is_tail [$];
    string      cmp_name;
    mmio_word_t cmp_value;
    mmio_word_t cmp_mask;
    bit         cmp_is_tail;
    int         fail_count;
    bit         frames_done;

    tb_clkgen clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    uart_mmio_top uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .uart_rx_line (uart_rx_line),
        .cmd_start    (cmd_start),
        .cmd_write    (cmd_write),
        .addr         (addr),
        .wdata        (wdata),
        .cmd_ready    (cmd_ready),
        .rdata        (rdata),
        .rdata_valid  (rdata_valid)
    );

    bind mmio_uart_rx tb_top_sva sva (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd_start   (cmd_start),
        .cmd_write   (cmd_write),
        .cmd_ready   (cmd_ready),
        .rx_valid    (rx_valid),
        .rdata_valid (rdata_valid),
        .rdata       (rdata)
    );

    // ##################################################
    // reference model
    // ##################################################

    // byte k lives in word k/4, lane k%4, and the newest byte wins after a wrap
    function automatic mmio_word_t model_word(input uart_byte_t bytes [$], input int n,
                                              input int idx);
        mmio_word_t w;
        int         p;
        w = '0;
        for (int lane = 0; lane < 4; lane++) begin
            p = idx * 4 + lane;
            if (n > p) begin
                w[lane*8 +: 8] = bytes[p + ring_bytes * ((n - 1 - p) / ring_bytes)];
            end
        end
        return w;
    endfunction

    function automatic mmio_word_t model_mask(input int n, input int idx);
        mmio_word_t m;
        m = '0;
        for (int lane = 0; lane < 4; lane++) begin
            if (n > idx * 4 + lane) begin
                m[lane*8 +: 8] = 8'hff;                   // lanes never written stay undefined
            end
        end
        return m;
    endfunction

    // ##################################################
    // checks
    // ##################################################

    task automatic stop_on_error();
        fail_count++;
        $display("TEST FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input string name, input mmio_word_t actual,
                              input mmio_word_t expected, input mmio_word_t mask);
        if ((actual & mask) !== (expected & mask)) begin
            $display("Fail %s: got %h, expected %h (lanes %h)", name, actual, expected, mask);
            stop_on_error();
        end
    endtask

    task automatic check_tail(input string name, input rx_tail_t actual, input rx_tail_t expected);
        if (actual !== expected) begin
            $display("Fail %s: got %h, expected %h", name, actual, expected);
            stop_on_error();
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && rdata_valid) begin
            if (exp_name.size() == 0) begin
                $display("rdata_valid was raised with no read outstanding");
                stop_on_error();
            end else begin
                cmp_name    = exp_name.pop_front();
                cmp_value   = exp_value.pop_front();
                cmp_mask    = exp_mask.pop_front();
                cmp_is_tail = exp_is_tail.pop_front();
                if (cmp_is_tail) begin
                    check_tail(cmp_name, rdata[$bits(rx_tail_t)-1:0], rx_tail_t'(cmp_value));
                end else begin
                    check_word(cmp_name, rdata, cmp_value, cmp_mask);
                end
            end
        end
    end

    // ##################################################
    // serial and bus drivers
    // ##################################################

    task automatic send_frame(input uart_byte_t data, input logic stop_level);
        @(negedge clk);
        uart_rx_line = 1'b0;
        repeat (clks_per_bit) @(negedge clk);
        for (int i = 0; i < data_bits; i++) begin
            uart_rx_line = data[i];
            repeat (clks_per_bit) @(negedge clk);
        end
        uart_rx_line = stop_level;
        // the byte lands in the ring a few cycles after the middle of the stop bit
        repeat (half_bit + 5) @(negedge clk);
        if (stop_level) begin
            byte_log.push_back(data);
        end
        repeat (clks_per_bit - half_bit - 5) @(negedge clk);
        uart_rx_line = 1'b1;
    endtask

    task automatic expect_read(input string name, input mmio_word_t value,
                               input mmio_word_t mask, input bit is_tail);
        exp_name.push_back(name);
        exp_value.push_back(value);
        exp_mask.push_back(mask);
        exp_is_tail.push_back(is_tail);
    endtask

    task automatic bus_read(input mmio_word_t a);
        int n;
        int idx;
        @(negedge clk);
        cmd_start = 1'b1;
        cmd_write = 1'b0;
        addr      = a;
        while (cmd_ready !== 1'b1) @(negedge clk);
        n = byte_log.size();                              // ring contents at the accept edge
        if (a == tail_offset) begin
            expect_read("rdata tail", mmio_word_t'(n % ring_bytes), '1, 1'b1);
        end else if (a == count_offset) begin
            expect_read("rdata count", mmio_word_t'(n / ring_bytes), '1, 1'b0);
        end else begin
            idx = int'(a[ring_addr_bits+1:2]);
            expect_read($sformatf("rdata ring[%0d]", idx), model_word(byte_log, n, idx),
                        model_mask(n, idx), 1'b0);
        end
        @(negedge clk);
        cmd_start = 1'b0;
        @(negedge clk);
    endtask

    task automatic bus_write(input mmio_word_t a, input mmio_word_t d);
        @(negedge clk);
        cmd_start = 1'b1;
        cmd_write = 1'b1;
        addr      = a;
        wdata     = d;
        while (cmd_ready !== 1'b1) @(negedge clk);
        @(negedge clk);
        cmd_start = 1'b0;
        cmd_write = 1'b0;
    endtask

    task automatic read_everything();
        bus_read(tail_offset);
        bus_read(count_offset);
        for (int w = 0; w < ring_words; w++) begin
            bus_read(mmio_word_t'(w * 4));
        end
    endtask

    // ##################################################
    // test sequence and watchdog
    // ##################################################

    initial begin
        #(watchdog_ns);
        $display("timeout: the run did not finish within %0d ns", watchdog_ns);
        stop_on_error();
    end

    initial begin
        void'($urandom(32'ha712_547b));
        uart_rx_line = 1'b1;
        cmd_start    = 1'b0;
        cmd_write    = 1'b0;
        addr         = '0;
        wdata        = '0;
        fail_count   = 0;
        frames_done  = 1'b0;
        @(posedge rst_n);
        @(negedge clk);

        if (cmd_ready !== 1'b1) begin
            $display("Fail cmd_ready: got %h, expected 1", cmd_ready);
            stop_on_error();
        end
        bus_read(tail_offset);
        bus_read(count_offset);

        repeat (40) send_frame(uart_byte_t'($urandom()), 1'b1);
        read_everything();

        // reads keep the bus busy while frames arrive
        fork
            begin
                repeat (24) send_frame(uart_byte_t'($urandom()), 1'b1);
                frames_done = 1'b1;
            end
            begin
                while (!frames_done) begin
                    case ($urandom_range(2))
                        0:       bus_read(tail_offset);
                        1:       bus_read(count_offset);
                        default: bus_read(mmio_word_t'(byte_log.size() % ring_bytes));
                    endcase
                end
            end
        join
        read_everything();

        send_frame(uart_byte_t'($urandom()), 1'b0);       // low stop bit
        repeat (2 * clks_per_bit) @(negedge clk);
        read_everything();

        bus_write(tail_offset, mmio_word_t'($urandom()));
        bus_write(count_offset, mmio_word_t'($urandom()));
        for (int w = 0; w < 8; w++) begin
            bus_write(mmio_word_t'(w * 4), mmio_word_t'($urandom()));
        end
        bus_write(mmio_word_t'($urandom()), mmio_word_t'($urandom()));
        read_everything();

        while (byte_log.size() < 1030) begin
            send_frame(uart_byte_t'($urandom()), 1'b1);
        end
        read_everything();

        repeat (4) @(negedge clk);
        if (exp_name.size() != 0) begin
            $display("%0d reads never returned a result", exp_name.size());
            stop_on_error();
        end
        if (fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_top_sva.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top_sva
    import mmio_pkg::*;
(
    input wire             clk,
    input wire             rst_n,
    input wire             cmd_start,
    input wire             cmd_write,
    input wire             cmd_ready,
    input wire             rx_valid,
    input wire             rdata_valid,
    input wire mmio_word_t rdata
);

    logic read_taken;

    assign read_taken = cmd_start && cmd_ready && !cmd_write;

    a_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
        rdata_valid |-> !$past(rdata_valid))
        else $error("rdata_valid was high in two cycles in a row");

    // a read result shows up two cycles after the accept and at no other time
    a_valid_timing: assert property (@(posedge clk) disable iff (!rst_n)
        rdata_valid == $past(read_taken, 2))
        else $error("rdata_valid does not follow an accepted read by two cycles");

    a_store_blocks: assert property (@(posedge clk) disable iff (!rst_n)
        (rx_valid || $past(rx_valid) || $past(rx_valid, 2)) |-> !cmd_ready)
        else $error("cmd_ready was high while a received byte was being stored");

    a_rdata_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !rdata_valid |-> rdata === $past(rdata))
        else $error("rdata changed outside of a read result");

endmodule

`default_nettype wire

//--- tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                            // 10 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- uart_mmio_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_mmio_top
    import uart_pkg::*;
    import mmio_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,
    input  wire             uart_rx_line,

    input  wire             cmd_start,
    input  wire             cmd_write,
    input  wire mmio_word_t addr,
    input  wire mmio_word_t wdata,
    output logic            cmd_ready,
    output mmio_word_t      rdata,
    output logic            rdata_valid
);

    uart_byte_t rx_byte;
    logic       rx_valid;

    uart_rx u_rx (
        .clk          (clk),
        .rst_n        (rst_n),
        .uart_rx_line (uart_rx_line),
        .rx_byte      (rx_byte),
        .rx_valid     (rx_valid)
    );

    mmio_uart_rx u_ring (
        .clk         (clk),
        .rst_n       (rst_n),
        .rx_byte     (rx_byte),
        .rx_valid    (rx_valid),
        .cmd_start   (cmd_start),
        .cmd_write   (cmd_write),
        .addr        (addr),
        .wdata       (wdata),
        .cmd_ready   (cmd_ready),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

endmodule

`default_nettype wire

//--- mmio_uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module mmio_uart_rx
    import uart_pkg::*;
    import mmio_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,

    input  wire uart_byte_t rx_byte,
    input  wire             rx_valid,

    input  wire             cmd_start,
    input  wire             cmd_write,
    input  wire mmio_word_t addr,
    input  wire mmio_word_t wdata,          // the ring is read-only from the bus
    output logic            cmd_ready,
    output mmio_word_t      rdata,
    output logic            rdata_valid
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_FETCH,
        S_RD_DONE,
        S_WR,
        S_ST_READ,
        S_ST_WRITE
    } state_t;

    state_t                    state;

    mmio_word_t                ring [ring_words];
    mmio_word_t                mem_rdata;
    mmio_word_t                merged;
    logic [ring_addr_bits-1:0] rd_addr;
    logic [ring_addr_bits-1:0] tail_word;

    rx_tail_t                  tail;
    mmio_word_t                count;
    uart_byte_t                store_byte;
    uart_byte_t                pend_byte;
    logic                      pend_valid;
    logic                      sel_tail;
    logic                      sel_count;
    logic                      finishing;
    logic                      take_byte;

    // ##################################################
    // control outputs and shared read port
    // ##################################################

    assign tail_word   = tail[ring_addr_bits+1:2];
    assign cmd_ready   = (state == S_IDLE) && !rx_valid;   // a new byte wins over the bus
    assign rdata_valid = (state == S_RD_DONE);

    // states from which the FSM would return to idle
    assign finishing = (state == S_RD_DONE) || (state == S_WR) || (state == S_ST_WRITE);
    assign take_byte = finishing && (pend_valid || rx_valid);

    // bus reads are fetched in the accept cycle, stores one cycle after the byte
    assign rd_addr = (state == S_ST_READ) ? tail_word : addr[ring_addr_bits+1:2];

    always_comb begin
        merged = mem_rdata;
        merged[$bits(uart_byte_t)*tail[1:0] +: $bits(uart_byte_t)] = store_byte;
    end

    // ##################################################
    // ring memory
    // ##################################################

    always_ff @(posedge clk) begin
        if (state == S_ST_WRITE) begin
            ring[tail_word] <= merged;
        end
        mem_rdata <= ring[rd_addr];
    end

    // ##################################################
    // control FSM, tail and wrap count
    // ##################################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            tail       <= '0;
            count      <= '0;
            pend_valid <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (rx_valid) begin
                        state <= S_ST_READ;
                    end else if (cmd_start) begin
                        state <= cmd_write ? S_WR : S_RD_FETCH;
                    end
                end
                S_RD_FETCH: state <= S_RD_DONE;
                S_ST_READ:  state <= S_ST_WRITE;
                default:    state <= take_byte ? S_ST_READ : S_IDLE;
            endcase

            if (state == S_ST_WRITE) begin
                tail <= tail + 1'b1;
                if (tail == '1) begin
                    count <= count + 1'b1;                // tail wraps to zero
                end
            end

            if (finishing && pend_valid) begin
                pend_valid <= rx_valid;                   // held byte moves on, a new one may replace it
            end else if (rx_valid && (state == S_RD_FETCH || state == S_ST_READ)) begin
                pend_valid <= 1'b1;
            end
        end
    end

    // ##################################################
    // byte holding and read data
    // ##################################################

    always_ff @(posedge clk) begin
        if (state == S_IDLE && rx_valid) begin
            store_byte <= rx_byte;
        end else if (take_byte) begin
            store_byte <= pend_valid ? pend_byte : rx_byte;
        end

        if (rx_valid && state != S_IDLE) begin
            pend_byte <= rx_byte;
        end

        if (cmd_start && cmd_ready) begin
            sel_tail  <= (addr == tail_offset);
            sel_count <= (addr == count_offset);
        end

        if (state == S_RD_FETCH) begin
            if (sel_tail) begin
                rdata <= mmio_word_t'(tail);
            end else if (sel_count) begin
                rdata <= count;
            end else begin
                rdata <= mem_rdata;
            end
        end
    end

endmodule

`default_nettype wire

//--- uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx
    import uart_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        uart_rx_line,
    output uart_byte_t rx_byte,
    output logic       rx_valid
);

    typedef enum logic [1:0] {
        R_IDLE,
        R_START,
        R_DATA,
        R_STOP
    } rx_state_t;

    rx_state_t               state;
    logic                    rx_meta;
    logic                    rx_sync;
    logic [tick_bits-1:0]    tick;
    logic [bit_idx_bits-1:0] bit_idx;
    uart_byte_t              shift;
    logic                    tick_end;

    // ##################################################
    // line synchronizer
    // ##################################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;                              // line idles high
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= uart_rx_line;
            rx_sync <= rx_meta;
        end
    end

    assign tick_end = (tick == tick_bits'(clks_per_bit - 1));

    // ##################################################
    // frame receiver
    // ##################################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= R_IDLE;
            tick     <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                R_IDLE: begin
                    tick <= '0;
                    if (!rx_sync) begin
                        state <= R_START;
                    end
                end
                R_START: begin
                    if (tick == tick_bits'(half_bit - 1)) begin
                        tick    <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? R_IDLE : R_DATA;   // a short glitch is no start bit
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                R_DATA: begin
                    if (tick_end) begin
                        tick    <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == bit_idx_bits'(data_bits - 1)) begin
                            state <= R_STOP;
                        end
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                default: begin
                    if (tick_end) begin
                        rx_valid <= rx_sync;                   // low stop bit drops the frame
                        state    <= R_IDLE;
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
            endcase
        end
    end

    // data arrives lsb first, each bit sampled at its middle
    always_ff @(posedge clk) begin
        if (state == R_DATA && tick_end) begin
            shift <= {rx_sync, shift[data_bits-1:1]};
        end
        if (state == R_STOP && tick_end) begin
            rx_byte <= shift;
        end
    end

endmodule

`default_nettype wire

//--- mmio_pkg.sv
`default_nettype none

package mmio_pkg;

    // ##################################################
    // bus words
    // ##################################################

    typedef logic [31:0] mmio_word_t;                     // bus address or data word

    // ##################################################
    // ring geometry with four received bytes per word
    // ##################################################

    localparam int ring_words     = 256;
    localparam int ring_addr_bits = $clog2(ring_words);   // word index width

    typedef logic [ring_addr_bits+1:0] rx_tail_t;         // byte index with the lane in the low two bits

    // ##################################################
    // memory map where any other address selects a ring word
    // ##################################################

    localparam mmio_word_t tail_offset  = 32'h0000_0400;
    localparam mmio_word_t count_offset = 32'h0000_0404;

endpackage

`default_nettype wire

//--- uart_pkg.sv
`default_nettype none

package uart_pkg;

    // ##################################################
    // serial line format is 8N1 with a fixed oversampling rate
    // ##################################################

    localparam int clks_per_bit = 16;                     // clock cycles per serial bit
    localparam int half_bit     = clks_per_bit / 2;       // start bit is confirmed here
    localparam int data_bits    = 8;

    localparam int tick_bits    = $clog2(clks_per_bit);   // width of the bit-period counter
    localparam int bit_idx_bits = $clog2(data_bits);      // width of the data bit index

    // ##################################################
    // payload
    // ##################################################

    typedef logic [data_bits-1:0] uart_byte_t;            // one received data byte

endpackage

`default_nettype wire
